// File: hdl/dmm_pkg.sv
// shared definitions for the multimeter control core
// register map, spi chip-select codes, mode codes and the bus structs
// every rtl module of the core takes what it needs by wildcard import
`default_nettype none

package dmm_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int REG_W       = 32;
  localparam int ADDR_W      = 8;
  localparam int FRAME_W     = ADDR_W + REG_W;  // addr byte then data, both msb first
  localparam int ADDR_WR_BIT = ADDR_W - 1;      // set in the addr byte for a write
  localparam int CS_W        = 3;
  localparam int MODE_W      = 3;
  localparam int SEQ_ENTRY_W = 6;
  localparam int SEQ_IDX_W   = 2;
  localparam int SEQ_N_W     = 3;
  localparam int SEQ_DEPTH   = 4;               // entries in a sequence
  localparam int COUNT_W     = 24;

  //////////////////////////////////////////////////
  // register map, address without the write bit
  localparam logic [ADDR_W-1:0] ADDR_DIRECT    = 8'd1;
  localparam logic [ADDR_W-1:0] ADDR_CR        = 8'd2;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 8'd3;   // read only
  localparam logic [ADDR_W-1:0] ADDR_SEQ_N     = 8'd4;
  localparam logic [ADDR_W-1:0] ADDR_SEQ0      = 8'd5;   // seq1..seq3 follow
  localparam logic [ADDR_W-1:0] ADDR_PRECHARGE = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_APERTURE  = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_4094_OE   = 8'd11;

  // chip-select vector codes, decimal
  localparam logic [CS_W-1:0] CS_DEASSERT   = 3'd0;
  localparam logic [CS_W-1:0] CS_FPGA       = 3'd1;
  localparam logic [CS_W-1:0] CS_4094       = 3'd2;
  localparam logic [CS_W-1:0] CS_INVERT_DAC = 3'd3;
  localparam logic [CS_W-1:0] CS_MDAC1      = 3'd4;

  localparam logic [MODE_W-1:0] MODE_DIRECT   = 3'd0;
  localparam logic [MODE_W-1:0] MODE_SEQ_MOCK = 3'd6;   // sequencer with mocked adc

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  //////////////////////////////////////////////////
  // structs
  typedef struct packed {
    logic [1:0] pc_sw;   // top 2 bits
    logic [3:0] azmux;   // low 4 bits
  } seq_entry_t;

  typedef struct packed {
    logic [SEQ_N_W-1:0]                  seq_n;      // already clamped to 1..4
    seq_entry_t [SEQ_DEPTH-1:0]          seq;
    logic [COUNT_W-1:0]                  precharge;  // clk counts
    logic [COUNT_W-1:0]                  aperture;
  } seq_cfg_t;

  typedef struct packed {
    logic [SEQ_IDX_W-1:0] sample_idx_last;
    logic                 first_last;
  } seq_status_t;

  // pin bus, leds at the lsb
  typedef struct packed {
    logic       adc_reset_n;
    logic       meas_complete;
    logic       spi_interrupt;
    logic       cmpr_latch;
    logic       adc_sigmux;
    logic       adc_rstmux;
    logic [1:0] adc_refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } pin_bus_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic ss_n;   // register set select, active lo
  } spi_line_t;

endpackage

`default_nettype wire

// File: hdl/spi_frontend.sv
// spi front end of the core
// routes sck/sdi to the external devices or parks them while the fpga is
// addressed, and hands a synchronized copy of the lines to the register bank
`timescale 1ns/100ps
`default_nettype none

module spi_frontend import dmm_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [CS_W-1:0] spi_cs_vec_i,
  input  logic            spi_sck_i,
  input  logic            spi_sdi_i,
  output spi_line_t       spi_line_o,
  output logic            spi_glb_clk_o,
  output logic            spi_glb_mosi_o,
  output logic            spi_4094_strobe_o,
  output logic            spi_invert_dac_ss_o,
  output logic            spi_invert_dac_clk_o,
  output logic            spi_invert_dac_data_o,
  output logic            spi_iso_cs_o,
  output logic            spi_iso_cs2_o
);

  logic [CS_W-1:0] cs_meta_q;
  logic [CS_W-1:0] cs_q;
  logic [1:0]      sck_sync_q;   // [1] is the stable copy
  logic [1:0]      sdi_sync_q;
  logic            fpga_sel;

  //////////////////////////////////////////////////
  // device routing, combinational on the raw pins
  assign fpga_sel = (spi_cs_vec_i == CS_FPGA);

  assign spi_glb_clk_o         = fpga_sel ? 1'b1 : spi_sck_i;   // park hi
  assign spi_glb_mosi_o        = fpga_sel ? 1'b1 : spi_sdi_i;   // park hi
  assign spi_4094_strobe_o     = (spi_cs_vec_i == CS_4094);     // active hi
  assign spi_invert_dac_ss_o   = (spi_cs_vec_i != CS_INVERT_DAC);
  assign spi_invert_dac_clk_o  = spi_glb_clk_o;
  assign spi_invert_dac_data_o = spi_glb_mosi_o;
  assign spi_iso_cs_o          = (spi_cs_vec_i != CS_MDAC1);    // isolated mdac
  assign spi_iso_cs2_o         = 1'b1;                          // no device fitted

  //////////////////////////////////////////////////
  // two flop synchronizers into clk_i
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_meta_q  <= CS_DEASSERT;
      cs_q       <= CS_DEASSERT;
      sck_sync_q <= '0;
      sdi_sync_q <= '0;
    end else begin
      cs_meta_q  <= spi_cs_vec_i;
      cs_q       <= cs_meta_q;
      sck_sync_q <= {sck_sync_q[0], spi_sck_i};
      sdi_sync_q <= {sdi_sync_q[0], spi_sdi_i};
    end
  end

  assign spi_line_o.sck  = sck_sync_q[1];
  assign spi_line_o.mosi = sdi_sync_q[1];
  assign spi_line_o.ss_n = (cs_q != CS_FPGA);   // only code 1 selects the register set

endmodule

`default_nettype wire

// File: hdl/register_bank.sv
// spi register set
// 40 bit frames: addr byte (bit 7 = write) then 32 data bits, msb first.
// sck is oversampled, mosi taken on rising edges, miso shifted on falling.
// a read loads the register after the addr byte, a write lands on bit 40
`timescale 1ns/100ps
`default_nettype none

module register_bank import dmm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  spi_line_t         spi_line_i,
  input  logic [REG_W-1:0]  status_i,
  output logic              spi_sdo_o,
  output logic [MODE_W-1:0] mode_o,
  output pin_bus_t          direct_pins_o,
  output seq_cfg_t          seq_cfg_o,
  output logic              oe_4094_o
);

  localparam int BIT_CNT_W = $clog2(FRAME_W + 1);

  logic                 sck_q;        // last sampled sck
  logic                 sck_rise;
  logic                 sck_fall;
  logic [BIT_CNT_W-1:0] bit_cnt_q;    // rising edges this frame
  logic [FRAME_W-1:0]   shift_q;
  logic [FRAME_W-1:0]   frame_next;   // shift_q plus the current mosi bit
  logic [REG_W-1:0]     tx_q;         // readback shifter
  logic [REG_W-1:0]     rd_data;
  logic [ADDR_W-1:0]    rd_addr;
  logic [ADDR_W-1:0]    wr_addr;
  logic                 wr_en;
  logic [REG_W-1:0]     seq_n_raw;
  logic [REG_W-1:0]     regs_q [ADDR_DIRECT:ADDR_4094_OE];   // status slot never written

  function automatic logic is_rw(input logic [ADDR_W-1:0] a);
    return (a >= ADDR_DIRECT) && (a <= ADDR_4094_OE) && (a != ADDR_STATUS);
  endfunction

  assign sck_rise   = spi_line_i.sck & ~sck_q;
  assign sck_fall   = ~spi_line_i.sck & sck_q;
  assign frame_next = {shift_q[FRAME_W-2:0], spi_line_i.mosi};

  // addr byte complete on the 8th edge. a write addr has bit 7 set and reads as 0
  assign rd_addr = frame_next[ADDR_W-1:0];
  assign wr_addr = {1'b0, frame_next[FRAME_W-2 -: ADDR_W-1]};
  assign wr_en   = !spi_line_i.ss_n && sck_rise
                   && (bit_cnt_q == BIT_CNT_W'(FRAME_W - 1))
                   && frame_next[FRAME_W-1 - (ADDR_W-1-ADDR_WR_BIT)]
                   && is_rw(wr_addr);

  always_comb begin
    rd_data = '0;   // unknown addr
    if (rd_addr == ADDR_STATUS) begin
      rd_data = status_i;
    end else if (is_rw(rd_addr)) begin
      rd_data = regs_q[rd_addr];
    end
  end

  //////////////////////////////////////////////////
  // frame engine
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q     <= 1'b0;
      bit_cnt_q <= '0;
      shift_q   <= '0;
      tx_q      <= '0;
      spi_sdo_o <= 1'b0;
    end else begin
      sck_q <= spi_line_i.sck;
      if (spi_line_i.ss_n) begin   // idle or cut off, partial frame dropped
        bit_cnt_q <= '0;
        shift_q   <= '0;
        tx_q      <= '0;
        spi_sdo_o <= 1'b0;
      end else if (sck_rise && bit_cnt_q != BIT_CNT_W'(FRAME_W)) begin
        shift_q   <= frame_next;
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == BIT_CNT_W'(ADDR_W - 1)) begin
          tx_q <= rd_data;   // first bit goes out on the next fall
        end
      end else if (sck_fall) begin
        spi_sdo_o <= tx_q[REG_W-1];
        tx_q      <= {tx_q[REG_W-2:0], 1'b0};
      end
    end
  end

  //////////////////////////////////////////////////
  // configuration registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = ADDR_DIRECT; i <= ADDR_4094_OE; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_addr] <= frame_next[REG_W-1:0];
    end
  end

  assign mode_o        = regs_q[ADDR_CR][MODE_W-1:0];
  assign direct_pins_o = pin_bus_t'(regs_q[ADDR_DIRECT][$bits(pin_bus_t)-1:0]);
  assign oe_4094_o     = regs_q[ADDR_4094_OE][0];   // lo at power up, 4094 outputs off
  assign seq_n_raw     = regs_q[ADDR_SEQ_N];

  always_comb begin
    if (seq_n_raw == '0) begin
      seq_cfg_o.seq_n = SEQ_N_W'(1);   // 0 runs a single entry
    end else if (seq_n_raw > REG_W'(SEQ_DEPTH)) begin
      seq_cfg_o.seq_n = SEQ_N_W'(SEQ_DEPTH);
    end else begin
      seq_cfg_o.seq_n = seq_n_raw[SEQ_N_W-1:0];
    end
    for (int i = 0; i < SEQ_DEPTH; i++) begin
      seq_cfg_o.seq[i] = seq_entry_t'(regs_q[ADDR_SEQ0 + i][SEQ_ENTRY_W-1:0]);
    end
    seq_cfg_o.precharge = regs_q[ADDR_PRECHARGE][COUNT_W-1:0];
    seq_cfg_o.aperture  = regs_q[ADDR_APERTURE][COUNT_W-1:0];
  end

endmodule

`default_nettype wire

// File: hdl/adc_mock.sv
// stand-in for the adc during sequencer bring up
// counts the aperture while held out of reset, then pulses measure_valid
// once and sits until adc_reset_n_i drops again
`timescale 1ns/100ps
`default_nettype none

module adc_mock import dmm_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               adc_reset_n_i,
  input  logic [COUNT_W-1:0] aperture_i,
  output logic               measure_valid_o
);

  logic [COUNT_W-1:0] cnt_q;
  logic               done_q;   // one pulse per release

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else if (!adc_reset_n_i) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done_q) begin
        if (cnt_q == aperture_i) begin   // valid seen aperture + 1 after release
          measure_valid_o <= 1'b1;
          done_q          <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/sequence_acquisition.sv
// sample acquisition sequencer
// steps through up to four azmux/pc_sw entries, each with a precharge phase
// and a measurement by the adc. held idle while trig_i is low.
// one step lasts precharge + aperture + 2 clk cycles
`timescale 1ns/100ps
`default_nettype none

module sequence_acquisition import dmm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        trig_i,
  input  logic        measure_valid_i,
  input  seq_cfg_t    cfg_i,
  output logic        adc_reset_n_o,
  output pin_bus_t    pins_o,
  output seq_status_t status_o
);

  // advance picks the entry and is the first precharge cycle
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADVANCE,
    ST_PRECHARGE,
    ST_MEASURE
  } state_t;

  state_t               state_q;
  logic [SEQ_IDX_W-1:0] idx_q;
  logic [SEQ_IDX_W-1:0] idx_next;
  logic [COUNT_W-1:0]   cnt_q;     // precharge cycles spent
  seq_entry_t           entry;
  seq_status_t          status_q;

  assign entry    = cfg_i.seq[idx_q];
  assign idx_next = (SEQ_N_W'(idx_q) + SEQ_N_W'(1) >= cfg_i.seq_n) ? '0 : idx_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      idx_q    <= '0;
      cnt_q    <= '0;
      status_q <= '0;
    end else if (!trig_i) begin   // restart from entry 0, last status kept
      state_q <= ST_IDLE;
      idx_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: state_q <= ST_ADVANCE;
        ST_ADVANCE: begin
          cnt_q   <= COUNT_W'(1);
          state_q <= (cfg_i.precharge > COUNT_W'(1)) ? ST_PRECHARGE : ST_MEASURE;
        end
        ST_PRECHARGE: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q + COUNT_W'(1) >= cfg_i.precharge) begin
            state_q <= ST_MEASURE;
          end
        end
        ST_MEASURE: begin
          if (measure_valid_i) begin   // only stall point
            status_q.sample_idx_last <= idx_q;
            status_q.first_last      <= (idx_q == '0);
            idx_q                    <= idx_next;
            state_q                  <= ST_ADVANCE;
          end
        end
      endcase
    end
  end

  assign adc_reset_n_o = (state_q == ST_MEASURE);   // adc released only here
  assign status_o      = status_q;

  //////////////////////////////////////////////////
  // pin bus, adc mux and ctl fields stay lo
  always_comb begin
    pins_o = '0;
    if (state_q != ST_IDLE) begin
      pins_o.azmux = entry.azmux;
      pins_o.pc_sw = entry.pc_sw;
    end
    pins_o.leds          = {2'b00, idx_q};
    pins_o.monitor[0]    = (state_q == ST_ADVANCE) || (state_q == ST_PRECHARGE);
    pins_o.monitor[1]    = (state_q == ST_MEASURE);
    pins_o.monitor[3:2]  = idx_q;
    pins_o.meas_complete = measure_valid_i;
  end

endmodule

`default_nettype wire

// File: hdl/mode_mux.sv
// output mode selection and status word assembly
// mode 0 drives the pins from the direct register, mode 6 from the
// sequencer, any other mode holds every pin lo
`timescale 1ns/100ps
`default_nettype none

module mode_mux import dmm_pkg::*; (
  input  logic [MODE_W-1:0]  mode_i,
  input  pin_bus_t           direct_i,
  input  pin_bus_t           seq_pins_i,
  input  seq_status_t        seq_status_i,
  input  logic [SEQ_N_W-1:0] seq_n_i,
  input  logic [3:0]         hw_flags_i,
  output pin_bus_t           pins_o,
  output logic [REG_W-1:0]   status_o
);

  always_comb begin
    case (mode_i)
      MODE_DIRECT:   pins_o = direct_i;     // every pin under host control
      MODE_SEQ_MOCK: pins_o = seq_pins_i;   // needs trig high
      default:       pins_o = '0;
    endcase
  end

  // status word, magic byte at the bottom
  assign status_o = {
    9'b0,                               // 31:23
    seq_n_i,                            // 22:20
    seq_status_i.first_last,            // 19
    1'b0,
    seq_status_i.sample_idx_last,       // 17:16
    4'b0,                               // 15:12
    hw_flags_i,                         // 11:8
    STATUS_MAGIC                        // 7:0
  };

endmodule

`default_nettype wire

// File: hdl/dmm_top.sv
// top level of the multimeter control core
// spi front end and register set on the input side, sequencer with the
// mocked adc in the middle, mode mux driving the output pins
`timescale 1ns/100ps
`default_nettype none

module dmm_top import dmm_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // spi
  input  logic [CS_W-1:0] spi_cs_vec_i,
  input  logic            spi_sck_i,
  input  logic            spi_sdi_i,
  output logic            spi_sdo_o,
  // shared lines and 4094
  output logic            spi_glb_clk_o,
  output logic            spi_glb_mosi_o,
  output logic            spi_4094_strobe_o,
  output logic            spi_4094_oe_o,
  // device selects
  output logic            spi_invert_dac_ss_o,
  output logic            spi_invert_dac_clk_o,
  output logic            spi_invert_dac_data_o,
  output logic            spi_iso_cs_o,
  output logic            spi_iso_cs2_o,
  input  logic [3:0]      hw_flags_i,
  input  logic            sa_trig_i,
  // pins
  output logic [3:0]      leds_o,
  output logic [7:0]      monitor_o,
  output logic [1:0]      pc_sw_o,
  output logic [3:0]      azmux_o,
  output logic [1:0]      adc_refmux_o,
  output logic            adc_sigmux_o,
  output logic            adc_rstmux_o,
  output logic            adc_cmpr_latch_o,
  output logic            spi_interrupt_o
);

  spi_line_t         spi_line;
  logic [MODE_W-1:0] mode;
  pin_bus_t          direct_pins;
  seq_cfg_t          seq_cfg;
  logic [REG_W-1:0]  status;
  logic              adc_reset_n;     // sequencer to adc
  logic              measure_valid;   // adc back to sequencer
  pin_bus_t          seq_pins;
  seq_status_t       seq_status;
  pin_bus_t          pins;            // selected bus

  //////////////////////////////////////////////////
  // input side
  spi_frontend spi_frontend0 (
    .clk_i, .rst_n_i, .spi_cs_vec_i, .spi_sck_i, .spi_sdi_i,
    .spi_line_o(spi_line),
    .spi_glb_clk_o, .spi_glb_mosi_o, .spi_4094_strobe_o,
    .spi_invert_dac_ss_o, .spi_invert_dac_clk_o, .spi_invert_dac_data_o,
    .spi_iso_cs_o, .spi_iso_cs2_o
  );

  register_bank register_bank0 (
    .clk_i, .rst_n_i,
    .spi_line_i(spi_line),
    .status_i(status),
    .spi_sdo_o,
    .mode_o(mode),
    .direct_pins_o(direct_pins),
    .seq_cfg_o(seq_cfg),
    .oe_4094_o(spi_4094_oe_o)
  );

  //////////////////////////////////////////////////
  // processing
  adc_mock adc_mock0 (
    .clk_i, .rst_n_i,
    .adc_reset_n_i(adc_reset_n),
    .aperture_i(seq_cfg.aperture),
    .measure_valid_o(measure_valid)
  );

  sequence_acquisition sequence_acquisition0 (
    .clk_i, .rst_n_i,
    .trig_i(sa_trig_i),
    .measure_valid_i(measure_valid),
    .cfg_i(seq_cfg),
    .adc_reset_n_o(adc_reset_n),
    .pins_o(seq_pins),
    .status_o(seq_status)
  );

  //////////////////////////////////////////////////
  // output side
  mode_mux mode_mux0 (
    .mode_i(mode),
    .direct_i(direct_pins),
    .seq_pins_i(seq_pins),
    .seq_status_i(seq_status),
    .seq_n_i(seq_cfg.seq_n),
    .hw_flags_i,
    .pins_o(pins),
    .status_o(status)
  );

  // unpack onto the pins, adc_reset_n and meas_complete have no pin here
  assign leds_o           = pins.leds;
  assign monitor_o        = pins.monitor;
  assign pc_sw_o          = pins.pc_sw;
  assign azmux_o          = pins.azmux;
  assign adc_refmux_o     = pins.adc_refmux;
  assign adc_sigmux_o     = pins.adc_sigmux;
  assign adc_rstmux_o     = pins.adc_rstmux;
  assign adc_cmpr_latch_o = pins.cmpr_latch;
  assign spi_interrupt_o  = pins.spi_interrupt;

endmodule

`default_nettype wire

// File: bench/dmm_top_properties.sv
// concurrent checks on the core, bound into dmm_top
// shared spi line parking, single-cycle measure_valid, one device select at a time
`timescale 1ns/100ps
`default_nettype none

module dmm_top_properties import dmm_pkg::*; (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic [CS_W-1:0] spi_cs_vec_i,
  input logic            spi_glb_clk_i,
  input logic            spi_glb_mosi_i,
  input logic            measure_valid_i,
  input logic            invert_dac_ss_i,
  input logic            iso_cs_i,
  input logic            iso_cs2_i
);

  // shared lines held hi while the register set is addressed
  a_parked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (spi_cs_vec_i == CS_FPGA) |-> (spi_glb_clk_i && spi_glb_mosi_i))
    else $error("shared spi lines not parked under the fpga select");

  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    measure_valid_i |=> !measure_valid_i)
    else $error("measure_valid high two cycles in a row");

  a_one_select: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones({~invert_dac_ss_i, ~iso_cs_i, ~iso_cs2_i}) <= 1)
    else $error("more than one active-low device select low");

endmodule

bind dmm_top dmm_top_properties props0 (
  .clk_i,
  .rst_n_i,
  .spi_cs_vec_i,
  .spi_glb_clk_i(spi_glb_clk_o),
  .spi_glb_mosi_i(spi_glb_mosi_o),
  .measure_valid_i(measure_valid),   // adc to sequencer net
  .invert_dac_ss_i(spi_invert_dac_ss_o),
  .iso_cs_i(spi_iso_cs_o),
  .iso_cs2_i(spi_iso_cs2_o)
);

`default_nettype wire

// File: bench/tb_dmm_top.sv
// directed testbench for the multimeter control core
// drives frames over the 3-bit chip-select spi port, checks register readback,
// device routing, direct mode, the mocked-adc sequencer and a cut-off frame
`timescale 1ns/100ps
`default_nettype none

module tb_dmm_top import dmm_pkg::*; ();

  localparam int CLK_HALF       = 50;      // 100 ns period
  localparam int STIM_DLY       = 10;      // drive point after the rising edge
  localparam int RESET_CYCLES   = 8;
  localparam int SCK_HALF       = 4;       // clk cycles per sck half period
  // ~37 frames of ~330 cycles plus the sequencer run, about doubled
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int STEP_CYCLES    = 14;      // precharge 5 + aperture 7 + 2

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic [CS_W-1:0] spi_cs_vec_i;
  logic            spi_sck_i;
  logic            spi_sdi_i;
  logic            spi_sdo_o;
  logic            spi_glb_clk_o;
  logic            spi_glb_mosi_o;
  logic            spi_4094_strobe_o;
  logic            spi_4094_oe_o;
  logic            spi_invert_dac_ss_o;
  logic            spi_invert_dac_clk_o;
  logic            spi_invert_dac_data_o;
  logic            spi_iso_cs_o;
  logic            spi_iso_cs2_o;
  logic [3:0]      hw_flags_i;
  logic            sa_trig_i;
  logic [3:0]      leds_o;
  logic [7:0]      monitor_o;
  logic [1:0]      pc_sw_o;
  logic [3:0]      azmux_o;
  logic [1:0]      adc_refmux_o;
  logic            adc_sigmux_o;
  logic            adc_rstmux_o;
  logic            adc_cmpr_latch_o;
  logic            spi_interrupt_o;

  int          errors       = 0;
  int          cycle_cnt    = 0;
  logic        verdict_done = 1'b0;
  logic [31:0] lfsr_q       = 32'h5c60_7822;

  dmm_top dut0 (.*);

  always #CLK_HALF clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      verdict_done = 1'b1;
      $finish;
    end
  end

  // run stopped by an assertion
  final begin
    if (!verdict_done) $display("Verification failed");
  end

  //////////////////////////////////////////////////
  // helpers
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #STIM_DLY;
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) r = {r[30:0], lfsr_bit()};
    return r;
  endfunction

  function automatic logic [SEQ_N_W-1:0] clamp_seq_n(input logic [REG_W-1:0] raw);
    if (raw == '0) return SEQ_N_W'(1);              // 0 runs one entry
    if (raw > REG_W'(SEQ_DEPTH)) return SEQ_N_W'(SEQ_DEPTH);
    return raw[SEQ_N_W-1:0];
  endfunction

  // status layout from bit 0 up
  function automatic logic [REG_W-1:0] expected_status(input logic [SEQ_N_W-1:0] seq_n,
      input logic [SEQ_IDX_W-1:0] idx, input logic first, input logic [3:0] flags);
    logic [REG_W-1:0] w;
    w        = '0;
    w[7:0]   = STATUS_MAGIC;
    w[11:8]  = flags;
    w[18:16] = {1'b0, idx};
    w[19]    = first;
    w[22:20] = seq_n;
    return w;
  endfunction

  // pins gathered back into a bus, the two internal fields stay 0
  function automatic pin_bus_t observed_pins();
    pin_bus_t p;
    p               = '0;
    p.leds          = leds_o;
    p.monitor       = monitor_o;
    p.pc_sw         = pc_sw_o;
    p.azmux         = azmux_o;
    p.adc_refmux    = adc_refmux_o;
    p.adc_rstmux    = adc_rstmux_o;
    p.adc_sigmux    = adc_sigmux_o;
    p.cmpr_latch    = adc_cmpr_latch_o;
    p.spi_interrupt = spi_interrupt_o;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input logic [REG_W-1:0] got,
                            input logic [REG_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_pins(input string name, input pin_bus_t got, input pin_bus_t exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // spi host, mode 0, sck idles low
  task automatic spi_frame(input logic [ADDR_W-1:0] addr_byte, input logic [REG_W-1:0] wdata,
                           input int nbits, output logic [REG_W-1:0] rdata);
    logic [FRAME_W-1:0] frame;
    frame        = {addr_byte, wdata};
    rdata        = '0;
    spi_cs_vec_i = CS_FPGA;
    wait_cycles(SCK_HALF);
    for (int i = 0; i < nbits; i++) begin
      spi_sdi_i = frame[FRAME_W-1-i];
      wait_cycles(SCK_HALF);
      if (i >= ADDR_W) rdata = {rdata[REG_W-2:0], spi_sdo_o};   // miso settled since the fall
      spi_sck_i = 1'b1;
      wait_cycles(SCK_HALF);
      spi_sck_i = 1'b0;
    end
    wait_cycles(SCK_HALF);
    spi_cs_vec_i = CS_DEASSERT;
    spi_sdi_i    = 1'b0;
    wait_cycles(SCK_HALF);   // select seen high before the next frame
  endtask

  task automatic spi_write(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
    logic [REG_W-1:0] unused;
    spi_frame({1'b1, addr[ADDR_WR_BIT-1:0]}, data, FRAME_W, unused);
  endtask

  task automatic spi_read(input logic [ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
    spi_frame({1'b0, addr[ADDR_WR_BIT-1:0]}, '0, FRAME_W, data);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic reset_state();
    logic [REG_W-1:0] rd;
    check_pins("pins after reset", observed_pins(), '0);
    check_bit("spi_sdo_o", spi_sdo_o, 1'b0);
    check_bit("spi_4094_oe_o", spi_4094_oe_o, 1'b0);
    check_bit("spi_4094_strobe_o", spi_4094_strobe_o, 1'b0);
    check_bit("spi_invert_dac_ss_o", spi_invert_dac_ss_o, 1'b1);
    check_bit("spi_iso_cs_o", spi_iso_cs_o, 1'b1);
    check_bit("spi_iso_cs2_o", spi_iso_cs2_o, 1'b1);
    spi_read(ADDR_STATUS, rd);
    check_word("status after reset", rd, expected_status(SEQ_N_W'(1), '0, 1'b0, hw_flags_i));
  endtask

  task automatic register_round_trip();
    logic [REG_W-1:0] vals [12];
    logic [REG_W-1:0] rd;
    for (int a = 1; a <= 11; a++) begin   // all writes first, catches aliasing
      if (ADDR_W'(a) == ADDR_STATUS) continue;
      vals[a] = rand_word(REG_W);
      spi_write(ADDR_W'(a), vals[a]);
    end
    for (int a = 1; a <= 11; a++) begin
      if (ADDR_W'(a) == ADDR_STATUS) continue;
      spi_read(ADDR_W'(a), rd);
      check_word($sformatf("reg 0x%0h", a), rd, vals[a]);
    end
    check_bit("spi_4094_oe_o", spi_4094_oe_o, vals[11][0]);
    spi_write(ADDR_STATUS, rand_word(REG_W));   // read only, ignored
    spi_read(ADDR_STATUS, rd);
    check_word("status", rd, expected_status(clamp_seq_n(vals[4]), '0, 1'b0, hw_flags_i));
  endtask

  task automatic cs_routing();
    logic sck_v;
    logic sdi_v;
    logic fpga;
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 2; k++) begin
        sck_v        = lfsr_bit();
        sdi_v        = lfsr_bit();
        fpga         = (CS_W'(c) == CS_FPGA);
        spi_cs_vec_i = CS_W'(c);
        spi_sck_i    = sck_v;
        spi_sdi_i    = sdi_v;
        wait_cycles(1);
        check_bit("spi_glb_clk_o", spi_glb_clk_o, fpga ? 1'b1 : sck_v);
        check_bit("spi_glb_mosi_o", spi_glb_mosi_o, fpga ? 1'b1 : sdi_v);
        check_bit("spi_invert_dac_clk_o", spi_invert_dac_clk_o, fpga ? 1'b1 : sck_v);
        check_bit("spi_invert_dac_data_o", spi_invert_dac_data_o, fpga ? 1'b1 : sdi_v);
        check_bit("spi_4094_strobe_o", spi_4094_strobe_o, CS_W'(c) == CS_4094);
        check_bit("spi_invert_dac_ss_o", spi_invert_dac_ss_o, CS_W'(c) != CS_INVERT_DAC);
        check_bit("spi_iso_cs_o", spi_iso_cs_o, CS_W'(c) != CS_MDAC1);
        check_bit("spi_iso_cs2_o", spi_iso_cs2_o, 1'b1);   // no code for it
      end
    end
    spi_cs_vec_i = CS_DEASSERT;
    spi_sck_i    = 1'b0;
    spi_sdi_i    = 1'b0;
    wait_cycles(SCK_HALF);
  endtask

  task automatic direct_mode();
    logic [REG_W-1:0] val;
    pin_bus_t         exp;
    val = rand_word(REG_W);
    spi_write(ADDR_CR, REG_W'(MODE_DIRECT));
    spi_write(ADDR_DIRECT, val);
    exp               = val[$bits(pin_bus_t)-1:0];
    exp.adc_reset_n   = 1'b0;   // no pin
    exp.meas_complete = 1'b0;
    check_pins("direct pins", observed_pins(), exp);
    spi_write(ADDR_CR, REG_W'(5));   // unused mode, all lo
    check_pins("mode 5 pins", observed_pins(), '0);
  endtask

  task automatic sequencer_run();
    seq_entry_t           entries [3];
    logic [REG_W-1:0]     rd;
    int                   n;
    entries[0] = 6'h13;
    entries[1] = 6'h25;
    entries[2] = 6'h39;
    spi_write(ADDR_SEQ_N, REG_W'(3));
    for (int i = 0; i < 3; i++) spi_write(ADDR_SEQ0 + ADDR_W'(i), REG_W'(entries[i]));
    spi_write(ADDR_PRECHARGE, REG_W'(5));
    spi_write(ADDR_APERTURE, REG_W'(7));
    spi_write(ADDR_CR, REG_W'(MODE_SEQ_MOCK));
    sa_trig_i = 1'b1;
    n = 0;
    while (!monitor_o[0] && n < 50) begin   // first precharge marker
      wait_cycles(1);
      n++;
    end
    if (!monitor_o[0]) begin
      errors++;
      $display("sequencer never entered precharge after the trigger went high");
    end
    for (int k = 0; k < 4; k++) begin   // entries 0 1 2 0
      check_word("azmux_o", {28'b0, azmux_o}, {28'b0, entries[k % 3].azmux});
      check_word("pc_sw_o", {30'b0, pc_sw_o}, {30'b0, entries[k % 3].pc_sw});
      check_word("leds_o", {28'b0, leds_o}, REG_W'(k % 3));
      n = 1;
      wait_cycles(1);
      while (azmux_o == entries[k % 3].azmux && pc_sw_o == entries[k % 3].pc_sw
             && n < 4 * STEP_CYCLES) begin
        n++;
        wait_cycles(1);
      end
      check_word("step cycles", REG_W'(n), REG_W'(STEP_CYCLES));
    end
    sa_trig_i = 1'b0;
    wait_cycles(2);
    spi_read(ADDR_STATUS, rd);
    // fourth step reran entry 0, so that was the last sample taken
    check_word("status after run", rd,
               expected_status(SEQ_N_W'(3), '0, 1'b1, hw_flags_i));
  endtask

  task automatic aborted_frame();
    logic [REG_W-1:0] keep;
    logic [REG_W-1:0] rd;
    keep = rand_word(REG_W);
    spi_write(ADDR_PRECHARGE, keep);
    spi_frame({1'b1, ADDR_PRECHARGE[ADDR_WR_BIT-1:0]}, ~keep, 20, rd);   // cut at bit 20
    spi_read(ADDR_PRECHARGE, rd);
    check_word("precharge after cut frame", rd, keep);
  endtask

  //////////////////////////////////////////////////
  initial begin
    rst_n_i      = 1'b0;
    spi_cs_vec_i = CS_DEASSERT;
    spi_sck_i    = 1'b0;
    spi_sdi_i    = 1'b0;
    hw_flags_i   = 4'hB;
    sa_trig_i    = 1'b0;
    wait_cycles(RESET_CYCLES);
    rst_n_i = 1'b1;
    wait_cycles(2);
    reset_state();
    register_round_trip();
    cs_routing();
    direct_mode();
    sequencer_run();
    aborted_frame();
    $display("checks done after %0d cycles, %0d errors", cycle_cnt, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    verdict_done = 1'b1;
    $finish;
  end

endmodule

`default_nettype wire

// File: dmm_top.f
hdl/dmm_pkg.sv
hdl/spi_frontend.sv
hdl/register_bank.sv
hdl/adc_mock.sv
hdl/sequence_acquisition.sv
hdl/mode_mux.sv
hdl/dmm_top.sv
bench/dmm_top_properties.sv
bench/tb_dmm_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f dmm_top.f \
  --top-module tb_dmm_top -o tb_dmm_top \
  && out="$(./obj_dir/tb_dmm_top)" \
  && echo "$out" \
  && echo "$out" | grep -q "Verification passed" \
  || { echo "simulation did not pass"; exit 1; }
